//--- source/tnoc_config_pkg.sv
package tnoc_config_pkg;
  //--------------------------------------------------------------------------
  //  Router geometry
  //--------------------------------------------------------------------------
  localparam int TNOC_PORTS       = 5;  // Local port plus four mesh neighbours
  localparam int TNOC_CHANNELS    = 2;  // Virtual channels per link
  localparam int TNOC_GRANT_DEPTH = 2;  // Entries in the grant order FIFO

  // Width of a channel number, at least one bit even with a single channel
  localparam int TNOC_VC_WIDTH =
    (TNOC_CHANNELS > 1) ? $clog2(TNOC_CHANNELS) : 1;

  //--------------------------------------------------------------------------
  //  Port index
  //--------------------------------------------------------------------------
  typedef enum logic [2:0] {
    PORT_LOCAL = 3'd0,  // Attached processing element
    PORT_EAST  = 3'd1,
    PORT_WEST  = 3'd2,
    PORT_NORTH = 3'd3,
    PORT_SOUTH = 3'd4
  } tnoc_port_e;

endpackage

//--- source/tnoc_flit_pkg.sv
package tnoc_flit_pkg;
  //--------------------------------------------------------------------------
  //  Flit fields
  //--------------------------------------------------------------------------
  localparam int TNOC_DATA_WIDTH = 32;  // Payload bits per flit

  // Position of a flit inside its packet
  typedef enum logic [1:0] {
    FLIT_HEAD   = 2'b00,  // First flit of a multi-flit packet
    FLIT_BODY   = 2'b01,
    FLIT_TAIL   = 2'b10,  // Last flit, closes the packet
    FLIT_SINGLE = 2'b11   // Head and tail in one flit
  } tnoc_flit_kind_e;

  // A single flit both opens and closes its packet
  function automatic logic is_head(tnoc_flit_kind_e kind);
    return (kind == FLIT_HEAD) || (kind == FLIT_SINGLE);
  endfunction

  function automatic logic is_tail(tnoc_flit_kind_e kind);
    return (kind == FLIT_TAIL) || (kind == FLIT_SINGLE);
  endfunction

endpackage

//--- source/tnoc_round_robin_arbiter.sv
`timescale 1ns/100ps

module tnoc_round_robin_arbiter #(
  parameter int REQUESTS = 2
)(
  input   var logic                 i_clk,
  input   var logic                 i_rst_n,
  input   var logic [REQUESTS-1:0]  i_request,
  input   var logic [REQUESTS-1:0]  i_free,
  output  var logic [REQUESTS-1:0]  o_grant
);
  localparam int PTR_WIDTH = (REQUESTS > 1) ? $clog2(REQUESTS) : 1;

  typedef enum logic {
    ARB_IDLE,             // No owner, grant follows requests
    ARB_HOLD              // Owner locked until its free pulse
  } arb_state_e;

  arb_state_e           state;
  logic [PTR_WIDTH-1:0] pointer;      // Highest priority requester
  logic [PTR_WIDTH-1:0] holder;       // Locked owner while in ARB_HOLD
  logic [PTR_WIDTH-1:0] winner;
  logic                 found;
  logic [PTR_WIDTH-1:0] grant_index;
  logic                 active;
  logic                 release_grant;
  logic [PTR_WIDTH-1:0] next_pointer;

  //--------------------------------------------------------------------------
  //  Pick the first requester at or after the pointer
  //--------------------------------------------------------------------------
  always_comb begin
    int idx;
    found  = 1'b0;
    winner = '0;
    // Scan downwards so the nearest requester is the one left standing
    for (int k = REQUESTS - 1; k >= 0; k--) begin
      idx = (int'(pointer) + k) % REQUESTS;
      if (i_request[idx]) begin
        found  = 1'b1;
        winner = PTR_WIDTH'(idx);
      end
    end
  end

  always_comb begin
    grant_index   = (state == ARB_HOLD) ? holder : winner;
    active        = (state == ARB_HOLD) || found;
    o_grant       = active ? (REQUESTS'(1'b1) << grant_index) : '0;
    release_grant = active && i_free[grant_index];  // Owner finished its packet
    next_pointer  = (grant_index == PTR_WIDTH'(REQUESTS - 1)) ? '0
                                                              : grant_index + 1'b1;
  end

  //--------------------------------------------------------------------------
  //  Hold state and pointer
  //--------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state   <= ARB_IDLE;
      pointer <= '0;
      holder  <= '0;
    end
    else if (release_grant) begin
      state   <= ARB_IDLE;          // Also covers a one-cycle packet
      pointer <= next_pointer;      // Move one past the owner
    end
    else if ((state == ARB_IDLE) && found) begin
      state   <= ARB_HOLD;
      holder  <= winner;
    end
  end

endmodule

//--- source/tnoc_grant_fifo.sv
`timescale 1ns/100ps

module tnoc_grant_fifo
  import tnoc_config_pkg::*;
(
  input   var logic                   i_clk,
  input   var logic                   i_rst_n,
  input   var logic                   i_push,
  input   var logic [TNOC_PORTS-1:0]  i_data,
  input   var logic                   i_pop,
  output  var logic                   o_full,
  output  var logic                   o_empty,
  output  var logic [TNOC_PORTS-1:0]  o_data
);
  localparam int DEPTH       = TNOC_GRANT_DEPTH;
  localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

  logic [DEPTH-1:0][TNOC_PORTS-1:0] entry;        // Entry 0 is the head
  logic [DEPTH-1:0][TNOC_PORTS-1:0] next_entry;
  logic [COUNT_WIDTH-1:0]           count;
  logic [COUNT_WIDTH-1:0]           next_count;
  logic [COUNT_WIDTH-1:0]           write_index;
  logic                             push_ok;
  logic                             pop_ok;

  always_comb begin
    push_ok = i_push && !o_full;   // Push into a full FIFO is dropped
    pop_ok  = i_pop && !o_empty;   // Pop of an empty FIFO is dropped
  end

  //--------------------------------------------------------------------------
  //  Shift on pop, write behind the last valid entry on push
  //--------------------------------------------------------------------------
  always_comb begin
    next_entry  = entry;
    write_index = pop_ok ? count - 1'b1 : count;
    if (pop_ok) begin
      for (int i = 0; i < DEPTH - 1; i++) begin
        next_entry[i] = entry[i+1];
      end
      next_entry[DEPTH-1] = '0;    // Empty slots read as no grant
    end
    if (push_ok) begin
      next_entry[write_index] = i_data;
    end
  end

  always_comb begin
    case ({push_ok, pop_ok})
      2'b10:   next_count = count + 1'b1;
      2'b01:   next_count = count - 1'b1;
      default: next_count = count;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      entry   <= '0;
      count   <= '0;
      o_full  <= 1'b0;
      o_empty <= 1'b1;
    end
    else begin
      entry   <= next_entry;
      count   <= next_count;
      o_full  <= (next_count == COUNT_WIDTH'(DEPTH));  // Registered flags
      o_empty <= (next_count == '0);
    end
  end

  assign o_data = entry[0];

endmodule

//--- source/tnoc_port_controller_internal.sv
`timescale 1ns/100ps

module tnoc_port_controller_internal
  import tnoc_config_pkg::*;
#(
  parameter int CHANNELS = TNOC_CHANNELS
)(
  input   var logic                                 i_clk,
  input   var logic                                 i_rst_n,
  input   var logic [CHANNELS-1:0]                  i_vc_ready,
  input   var logic [TNOC_PORTS-1:0][CHANNELS-1:0]  i_request,
  input   var logic [TNOC_PORTS-1:0][CHANNELS-1:0]  i_start_of_packet,
  input   var logic [TNOC_PORTS-1:0][CHANNELS-1:0]  i_end_of_packet,
  input   var logic [TNOC_PORTS-1:0][CHANNELS-1:0]  i_free,
  output  var logic [TNOC_PORTS-1:0][CHANNELS-1:0]  o_grant,
  output  var logic [TNOC_PORTS-1:0]                o_output_grant,
  input   var logic                                 i_output_free
);
  logic [CHANNELS-1:0][TNOC_PORTS-1:0] request;
  logic [CHANNELS-1:0][TNOC_PORTS-1:0] start_of_packet;
  logic [CHANNELS-1:0][TNOC_PORTS-1:0] end_of_packet;
  logic [CHANNELS-1:0][TNOC_PORTS-1:0] free;
  logic [CHANNELS-1:0][TNOC_PORTS-1:0] grant;

  // Port-major inputs become channel-major vectors
  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      for (int p = 0; p < TNOC_PORTS; p++) begin
        request[c][p]         = i_request[p][c];
        start_of_packet[c][p] = i_start_of_packet[p][c];
        end_of_packet[c][p]   = i_end_of_packet[p][c];
        free[c][p]            = i_free[p][c];
        o_grant[p][c]         = grant[c][p];
      end
    end
  end

  //--------------------------------------------------------------------------
  //  Port arbitration, one arbiter per channel
  //--------------------------------------------------------------------------
  logic [CHANNELS-1:0][TNOC_PORTS-1:0] port_grant;

  for (genvar c = 0; c < CHANNELS; c++) begin : g_port_arbitration
    tnoc_round_robin_arbiter #(
      .REQUESTS (TNOC_PORTS )
    ) u_arbiter (
      .i_clk      (i_clk              ),
      .i_rst_n    (i_rst_n            ),
      .i_request  (start_of_packet[c] ),  // Head flit claims the channel
      .i_free     (end_of_packet[c]   ),  // Tail flit gives it back
      .o_grant    (port_grant[c]      )
    );
  end

  //--------------------------------------------------------------------------
  //  Channel arbitration
  //--------------------------------------------------------------------------
  logic [CHANNELS-1:0] vc_grant;
  logic [CHANNELS-1:0] vc_free;

  always_comb begin
    for (int c = 0; c < CHANNELS; c++) begin
      vc_free[c] = |(free[c] & port_grant[c]);
    end
  end

  if (CHANNELS >= 2) begin : g_vc_arbitration
    logic [CHANNELS-1:0] vc_request;

    always_comb begin
      for (int c = 0; c < CHANNELS; c++) begin
        vc_request[c] = |(request[c] & port_grant[c]) && i_vc_ready[c];
      end
    end

    tnoc_round_robin_arbiter #(
      .REQUESTS (CHANNELS )
    ) u_arbiter (
      .i_clk      (i_clk      ),
      .i_rst_n    (i_rst_n    ),
      .i_request  (vc_request ),
      .i_free     (vc_free    ),
      .o_grant    (vc_grant   )
    );
  end
  else begin : g_vc_bypass
    // Nothing to choose between with one channel
    always_comb begin
      vc_grant = |(request[0] & port_grant[0]) && i_vc_ready[0];
    end
  end

  //--------------------------------------------------------------------------
  //  Grant and grant order FIFO
  //--------------------------------------------------------------------------
  logic                   fifo_full;
  logic                   fifo_push;
  logic [TNOC_PORTS-1:0]  output_grant;

  always_comb begin
    output_grant = '0;
    for (int c = 0; c < CHANNELS; c++) begin
      grant[c] = (vc_grant[c] && !fifo_full) ? port_grant[c] : '0;  // Back-pressure
      if (vc_grant[c]) begin
        output_grant |= port_grant[c];  // Owner of the winning channel
      end
    end
    fifo_push = |vc_free;
  end

  tnoc_grant_fifo u_grant_fifo (
    .i_clk    (i_clk          ),
    .i_rst_n  (i_rst_n        ),
    .i_push   (fifo_push      ),
    .i_data   (output_grant   ),
    .i_pop    (i_output_free  ),
    .o_full   (fifo_full      ),
    .o_empty  (),
    .o_data   (o_output_grant )
  );

endmodule

//--- source/tnoc_output_switch.sv
`timescale 1ns/100ps

module tnoc_output_switch
  import tnoc_config_pkg::*;
  import tnoc_flit_pkg::*;
(
  input   var logic                                       i_clk,
  input   var logic                                       i_rst_n,
  input   var logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   i_grant,
  input   var logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   i_request,
  input   var logic [TNOC_PORTS-1:0][TNOC_DATA_WIDTH-1:0] i_flit_data,
  input   var tnoc_flit_kind_e [TNOC_PORTS-1:0]           i_flit_kind,
  output  var logic                                       o_flit_valid,
  output  var logic [TNOC_DATA_WIDTH-1:0]                 o_flit_data,
  output  var tnoc_flit_kind_e                            o_flit_kind,
  output  var logic [TNOC_VC_WIDTH-1:0]                   o_flit_vc
);
  logic                     transfer;
  tnoc_port_e               sel_port;
  logic [TNOC_VC_WIDTH-1:0] sel_vc;

  //--------------------------------------------------------------------------
  //  Locate the transferring port and channel
  //--------------------------------------------------------------------------
  always_comb begin
    transfer = 1'b0;
    sel_port = PORT_LOCAL;
    sel_vc   = '0;
    for (int p = 0; p < TNOC_PORTS; p++) begin
      for (int c = 0; c < TNOC_CHANNELS; c++) begin
        if (i_grant[p][c] && i_request[p][c]) begin  // At most one hit
          transfer = 1'b1;
          sel_port = tnoc_port_e'(p);
          sel_vc   = TNOC_VC_WIDTH'(c);
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_flit_valid <= 1'b0;
    end
    else begin
      o_flit_valid <= transfer;
    end
  end

  always_ff @(posedge i_clk) begin
    if (transfer) begin
      o_flit_data <= i_flit_data[sel_port];
      o_flit_kind <= i_flit_kind[sel_port];
      o_flit_vc   <= sel_vc;            // Channel travels with the flit
    end
  end

endmodule

//--- source/tnoc_output_port.sv
`timescale 1ns/100ps

module tnoc_output_port
  import tnoc_config_pkg::*;
  import tnoc_flit_pkg::*;
(
  input   var logic                                       i_clk,
  input   var logic                                       i_rst_n,
  // Per port and channel control
  input   var logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   i_request,
  input   var logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   i_start_of_packet,
  input   var logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   i_end_of_packet,
  input   var logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   i_free,
  output  var logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   o_grant,
  // Per port flits
  input   var logic [TNOC_PORTS-1:0][TNOC_DATA_WIDTH-1:0] i_flit_data,
  input   var tnoc_flit_kind_e [TNOC_PORTS-1:0]           i_flit_kind,
  // Downstream side
  input   var logic [TNOC_CHANNELS-1:0]                   i_vc_ready,
  input   var logic                                       i_output_free,
  output  var logic [TNOC_PORTS-1:0]                      o_output_grant,
  output  var logic                                       o_flit_valid,
  output  var logic [TNOC_DATA_WIDTH-1:0]                 o_flit_data,
  output  var tnoc_flit_kind_e                            o_flit_kind,
  output  var logic [TNOC_VC_WIDTH-1:0]                   o_flit_vc
);

  tnoc_port_controller_internal #(
    .CHANNELS (TNOC_CHANNELS  )
  ) u_controller (
    .i_clk              (i_clk              ),
    .i_rst_n            (i_rst_n            ),
    .i_vc_ready         (i_vc_ready         ),
    .i_request          (i_request          ),
    .i_start_of_packet  (i_start_of_packet  ),
    .i_end_of_packet    (i_end_of_packet    ),
    .i_free             (i_free             ),
    .o_grant            (o_grant            ),
    .o_output_grant     (o_output_grant     ),
    .i_output_free      (i_output_free      )
  );

  // Grant vector from the controller steers the switch
  tnoc_output_switch u_switch (
    .i_clk        (i_clk        ),
    .i_rst_n      (i_rst_n      ),
    .i_grant      (o_grant      ),
    .i_request    (i_request    ),
    .i_flit_data  (i_flit_data  ),
    .i_flit_kind  (i_flit_kind  ),
    .o_flit_valid (o_flit_valid ),
    .o_flit_data  (o_flit_data  ),
    .o_flit_kind  (o_flit_kind  ),
    .o_flit_vc    (o_flit_vc    )
  );

endmodule

//--- dv/tnoc_output_port_asserts.sv
`timescale 1ns/100ps

module tnoc_output_port_asserts
  import tnoc_config_pkg::*;
(
  input var logic                                     i_clk,
  input var logic                                     i_rst_n,
  input var logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0] i_grant,
  input var logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0] i_end_of_packet,
  input var logic                                     i_fifo_full,
  input var logic                                     i_fifo_push
);
  logic [TNOC_CHANNELS-1:0] channel_active;

  for (genvar c = 0; c < TNOC_CHANNELS; c++) begin : g_channel
    logic [TNOC_PORTS-1:0] column;  // Grants of every port on this channel

    always_comb begin
      for (int p = 0; p < TNOC_PORTS; p++) begin
        column[p] = i_grant[p][c];
      end
    end

    assign channel_active[c] = |column;

    a_port_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      $onehot0(column)) else $error("Several ports granted on one channel");

    for (genvar p = 0; p < TNOC_PORTS; p++) begin : g_port
      a_grant_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_grant[p][c] && !i_end_of_packet[p][c]) |=> i_grant[p][c])
        else $error("Grant dropped before end of packet");
    end
  end

  a_channel_onehot: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(channel_active)) else $error("Several channels granted at once");

  // A packet may only finish when its grant could still be queued
  a_no_overflow: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_fifo_push |-> !i_fifo_full) else $error("Packet completed into a full grant FIFO");

endmodule

bind tnoc_port_controller_internal tnoc_output_port_asserts u_asserts (
  .i_clk            (i_clk            ),
  .i_rst_n          (i_rst_n          ),
  .i_grant          (o_grant          ),
  .i_end_of_packet  (i_end_of_packet  ),
  .i_fifo_full      (fifo_full        ),
  .i_fifo_push      (fifo_push        )
);

//--- dv/tnoc_output_port_tb.sv
`timescale 1ns/100ps

module tnoc_output_port_tb
  import tnoc_config_pkg::*;
  import tnoc_flit_pkg::*;
();
  localparam int TIMEOUT = 200;  // Cycles allowed for any wait

  logic                                       i_clk;
  logic                                       i_rst_n;
  logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   i_request;
  logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   i_start_of_packet;
  logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   i_end_of_packet;
  logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   i_free;
  logic [TNOC_PORTS-1:0][TNOC_CHANNELS-1:0]   o_grant;
  logic [TNOC_PORTS-1:0][TNOC_DATA_WIDTH-1:0] i_flit_data;
  tnoc_flit_kind_e [TNOC_PORTS-1:0]           i_flit_kind;
  logic [TNOC_CHANNELS-1:0]                   i_vc_ready;
  logic                                       i_output_free;
  logic [TNOC_PORTS-1:0]                      o_output_grant;
  logic                                       o_flit_valid;
  logic [TNOC_DATA_WIDTH-1:0]                 o_flit_data;
  tnoc_flit_kind_e                            o_flit_kind;
  logic [TNOC_VC_WIDTH-1:0]                   o_flit_vc;

  int expected_fifo[$];  // One-hot ports in push order
  int head_order[$];     // Ports in the order their heads transferred
  int vc_order[$];

  tnoc_output_port dut_i (
    .i_clk              (i_clk              ),
    .i_rst_n            (i_rst_n            ),
    .i_request          (i_request          ),
    .i_start_of_packet  (i_start_of_packet  ),
    .i_end_of_packet    (i_end_of_packet    ),
    .i_free             (i_free             ),
    .o_grant            (o_grant            ),
    .i_flit_data        (i_flit_data        ),
    .i_flit_kind        (i_flit_kind        ),
    .i_vc_ready         (i_vc_ready         ),
    .i_output_free      (i_output_free      ),
    .o_output_grant     (o_output_grant     ),
    .o_flit_valid       (o_flit_valid       ),
    .o_flit_data        (o_flit_data        ),
    .o_flit_kind        (o_flit_kind        ),
    .o_flit_vc          (o_flit_vc          )
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic clear_inputs();
    i_request         = '0;
    i_start_of_packet = '0;
    i_end_of_packet   = '0;
    i_free            = '0;
    i_flit_data       = '0;
    i_output_free     = 1'b0;
    i_vc_ready        = '1;
    for (int p = 0; p < TNOC_PORTS; p++) begin
      i_flit_kind[p] = FLIT_HEAD;
    end
  endtask

  task automatic apply_reset();
    @(negedge i_clk);
    i_rst_n = 1'b0;
    clear_inputs();
    repeat (2) @(negedge i_clk);
    i_rst_n = 1'b1;
    expected_fifo.delete();
    head_order.delete();
    vc_order.delete();
    check_value("reset grant", 0, 32'(o_grant));
    check_value("reset valid", 0, 32'(o_flit_valid));
    check_value("reset output grant", 0, 32'(o_output_grant));
  endtask

  // Starts and ends on a falling edge; each flit waits for its grant
  task automatic send_packet(input string name, input int port, input int vc,
                             input int flits, output int head_wait);
    logic [31:0]     data;
    tnoc_flit_kind_e kind;
    int              waited;
    head_wait = 0;
    for (int i = 0; i < flits; i++) begin
      data = $urandom();
      kind = (i == 0) ? FLIT_HEAD : (i == flits - 1) ? FLIT_TAIL : FLIT_BODY;
      i_request[port][vc]         = 1'b1;
      i_start_of_packet[port][vc] = (i == 0);
      i_end_of_packet[port][vc]   = (i == flits - 1);
      i_free[port][vc]            = (i == flits - 1);
      i_flit_data[port]           = data;
      i_flit_kind[port]           = kind;
      waited = 0;
      @(posedge i_clk);
      while (!o_grant[port][vc]) begin
        waited++;
        if (waited > TIMEOUT) stop_run($sformatf("%s: port %0d never granted", name, port));
        @(posedge i_clk);
      end
      if (i == 0) begin
        head_wait = waited;
        head_order.push_back(port);
        vc_order.push_back(vc);
      end
      @(negedge i_clk);
      check_value({name, " valid"}, 1, 32'(o_flit_valid));
      check_value({name, " data"}, data, o_flit_data);
      check_value({name, " kind"}, 32'(kind), 32'(o_flit_kind));
      check_value({name, " vc"}, vc, 32'(o_flit_vc));
    end
    i_request[port][vc]       = 1'b0;
    i_end_of_packet[port][vc] = 1'b0;
    i_free[port][vc]          = 1'b0;
  endtask

  // Pops entries in order, each checked against the expected push order
  task automatic pop_entries(input string name, input int count);
    int waited;
    for (int k = 0; k < count; k++) begin
      waited = 0;
      while (o_output_grant == '0) begin
        waited++;
        if (waited > TIMEOUT) stop_run($sformatf("%s: grant FIFO stayed empty", name));
        @(negedge i_clk);
      end
      if (expected_fifo.size() == 0) stop_run($sformatf("%s: unexpected FIFO entry", name));
      check_value({name, " fifo"}, expected_fifo.pop_front(), 32'(o_output_grant));
      i_output_free = 1'b1;
      @(negedge i_clk);
      i_output_free = 1'b0;
    end
  endtask

  // Drives a head flit by hand and checks it stays ungranted
  task automatic expect_blocked(input string name, input int port, input int vc);
    i_request[port][vc]         = 1'b1;
    i_start_of_packet[port][vc] = 1'b1;
    i_flit_kind[port]           = FLIT_HEAD;
    repeat (5) begin
      @(posedge i_clk);
      check_value({name, " blocked"}, 0, 32'(o_grant));
    end
    @(negedge i_clk);
  endtask

  //--------------------------------------------------------------------------
  //  Directed tests
  //--------------------------------------------------------------------------
  task automatic single_packet();
    int w;
    apply_reset();
    expected_fifo.push_back(32'(1) << PORT_EAST);
    send_packet("single", PORT_EAST, 0, 3, w);
    check_value("single head wait", 0, w);
    check_value("single output grant", 32'(1) << PORT_EAST, 32'(o_output_grant));
    pop_entries("single", 1);
  endtask

  task automatic port_round_robin();
    int w[TNOC_PORTS];
    apply_reset();
    for (int i = 0; i < TNOC_PORTS; i++) begin
      expected_fifo.push_back(32'(1) << i);  // Completion follows pointer order
    end
    fork
      send_packet("port_rr", PORT_LOCAL, 0, 3, w[0]);
      send_packet("port_rr", PORT_EAST,  0, 3, w[1]);
      send_packet("port_rr", PORT_WEST,  0, 3, w[2]);
      send_packet("port_rr", PORT_NORTH, 0, 3, w[3]);
      send_packet("port_rr", PORT_SOUTH, 0, 3, w[4]);
      pop_entries("port_rr", TNOC_PORTS);
    join
    check_value("port_rr count", TNOC_PORTS, head_order.size());
    for (int i = 0; i < TNOC_PORTS; i++) begin
      check_value("port_rr order", i, head_order[i]);  // Pointer starts at LOCAL
    end
  endtask

  task automatic ready_gating();
    int w;
    apply_reset();
    expected_fifo.push_back(32'(1) << PORT_NORTH);
    i_vc_ready[1] = 1'b0;
    expect_blocked("vc_ready", PORT_NORTH, 1);
    i_vc_ready[1] = 1'b1;
    send_packet("vc_ready", PORT_NORTH, 1, 2, w);
    check_value("vc_ready head wait", 0, w);
    pop_entries("vc_ready", 1);
  endtask

  task automatic channel_round_robin();
    int w[4];
    apply_reset();
    for (int i = 0; i < 4; i++) begin
      expected_fifo.push_back(32'(1) << ((i % 2 == 0) ? PORT_WEST : PORT_SOUTH));
    end
    fork
      begin
        send_packet("vc_rr", PORT_WEST, 0, 2, w[0]);
        send_packet("vc_rr", PORT_WEST, 0, 2, w[1]);
      end
      begin
        send_packet("vc_rr", PORT_SOUTH, 1, 2, w[2]);
        send_packet("vc_rr", PORT_SOUTH, 1, 2, w[3]);
      end
      pop_entries("vc_rr", 4);
    join
    check_value("vc_rr count", 4, vc_order.size());
    for (int i = 0; i < 4; i++) begin
      check_value("vc_rr order", i % 2, vc_order[i]);  // Pointer moves past each owner
    end
  endtask

  task automatic back_pressure();
    int w;
    apply_reset();
    expected_fifo.push_back(32'(1) << PORT_EAST);
    expected_fifo.push_back(32'(1) << PORT_WEST);
    expected_fifo.push_back(32'(1) << PORT_LOCAL);
    send_packet("backpressure", PORT_EAST, 0, 2, w);
    send_packet("backpressure", PORT_WEST, 0, 2, w);
    expect_blocked("backpressure", PORT_LOCAL, 0);
    pop_entries("backpressure", 1);
    send_packet("backpressure", PORT_LOCAL, 0, 2, w);
    check_value("backpressure head wait", 0, w);
    pop_entries("backpressure", 2);
  endtask

  initial begin
    void'($urandom(32'he6ef));
    i_rst_n = 1'b0;
    clear_inputs();
    single_packet();
    port_round_robin();
    ready_gating();
    channel_round_robin();
    back_pressure();
    $display("Test completed successfully");
    $finish;
  end

endmodule

//--- tnoc_output_port.f
source/tnoc_config_pkg.sv
source/tnoc_flit_pkg.sv
source/tnoc_round_robin_arbiter.sv
source/tnoc_grant_fifo.sv
source/tnoc_port_controller_internal.sv
source/tnoc_output_switch.sv
source/tnoc_output_port.sv
dv/tnoc_output_port_asserts.sv
dv/tnoc_output_port_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tnoc_output_port_tb
FILELIST = tnoc_output_port.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
